//--- Makefile
TOP = phxDecoderTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- logic/phxDecoder.sv
`include "phx_params.svh"

module phxDecoder (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	input  logic [`PHX_INSN_W-1:0] insn,
	input  logic [`PHX_INSN_W-1:0] pfx,
	input  logic [2:0] spSel,
	output logic outValid,
	output phxPkg::regSpec_t ra,
	output phxPkg::regSpec_t rb,
	output phxPkg::regSpec_t rc,
	output phxPkg::regSpec_t rt,
	output logic hasRa,
	output logic hasRb,
	output logic hasRc,
	output logic hasRt,
	output logic rfWr,
	output logic vrfWr,
	output logic isVector,
	output logic needSteps,
	output phxPkg::memSize_e memSize,
	output logic [`PHX_IMM_W-1:0] imm,
	output phxPkg::prec_e prec,
	output logic isLoad,
	output logic isStore,
	output logic loadUnsigned,
	output logic isBranch,
	output logic isCall,
	output logic multiCycle
);
	import phxPkg::*;

	logic isLoadDec, isStoreDec, loadReg, loadIdx, storeReg, storeIdx;
	logic loadUnsignedDec, isBranchDec, isCallDec, multiCycleDec;
	memSize_e baseSize, memSizeDec;
	prec_e precDec;
	regSpec_t raDec, rbDec, rcDec, rtDec;
	logic hasRaDec, hasRbDec, hasRcDec, hasRtDec;
	logic rfWrDec, vrfWrDec, isVectorDec, needStepsDec;
	logic [`PHX_IMM_W-1:0] immDec;

	// ====================
	// Decoders
	// ====================
	phxOpClassDecode uOpClass (
		.insn(insn), .pfx(pfx),
		.isLoad(isLoadDec), .isStore(isStoreDec),
		.loadReg(loadReg), .loadIdx(loadIdx),
		.storeReg(storeReg), .storeIdx(storeIdx),
		.loadUnsigned(loadUnsignedDec), .isBranch(isBranchDec),
		.isCall(isCallDec), .multiCycle(multiCycleDec),
		.baseSize(baseSize), .prec(precDec)
	);

	phxRegSpecDecode uRegSpec (
		.insn(insn), .spSel(spSel),
		.isBranch(isBranchDec), .isStore(isStoreDec), .isCall(isCallDec),
		.isLoad(isLoadDec), .loadIdx(loadIdx), .storeIdx(storeIdx),
		.storeReg(storeReg), .loadReg(loadReg), .baseSize(baseSize),
		.ra(raDec), .rb(rbDec), .rc(rcDec), .rt(rtDec),
		.hasRa(hasRaDec), .hasRb(hasRbDec), .hasRc(hasRcDec), .hasRt(hasRtDec),
		.rfWr(rfWrDec), .vrfWr(vrfWrDec), .isVector(isVectorDec),
		.needSteps(needStepsDec), .memSize(memSizeDec)
	);

	phxImmDecode uImm (.insn(insn), .pfx(pfx), .imm(immDec));

	// ====================
	// Output stage
	// ====================
	always_ff @(posedge clk) begin
		if (!rstN) begin
			outValid <= 1'b0;
			rfWr <= 1'b0;
			vrfWr <= 1'b0;
			isLoad <= 1'b0;
			isStore <= 1'b0;
		end else begin
			outValid <= inValid;
			if (inValid) begin
				rfWr <= rfWrDec;
				vrfWr <= vrfWrDec;
				isLoad <= isLoadDec;
				isStore <= isStoreDec;
			end
		end
	end

	// Fields hold until the next accepted word
	always_ff @(posedge clk) begin
		if (inValid) begin
			ra <= raDec;
			rb <= rbDec;
			rc <= rcDec;
			rt <= rtDec;
			hasRa <= hasRaDec;
			hasRb <= hasRbDec;
			hasRc <= hasRcDec;
			hasRt <= hasRtDec;
			isVector <= isVectorDec;
			needSteps <= needStepsDec;
			memSize <= memSizeDec;
			imm <= immDec;
			prec <= precDec;
			loadUnsigned <= loadUnsignedDec;
			isBranch <= isBranchDec;
			isCall <= isCallDec;
			multiCycle <= multiCycleDec;
		end
	end

endmodule

//--- logic/phxImmDecode.sv
`include "phx_params.svh"

module phxImmDecode (
	input  logic [`PHX_INSN_W-1:0] insn,
	input  logic [`PHX_INSN_W-1:0] pfx,
	output logic [`PHX_IMM_W-1:0] imm
);
	import phxPkg::*;

	opcode_e opc;
	logic pfxValid;
	logic [15:0] imm16;
	logic [31:0] target;
	logic [31:0] pfxImm;

	assign opc = opcode_e'(insn[`PHX_OPC_HI:`PHX_OPC_LO]);
	assign pfxValid = opcode_e'(pfx[`PHX_OPC_HI:`PHX_OPC_LO]) == OP_PFX;
	assign imm16 = insn[`PHX_IMM16_LO +: 16];
	assign target = insn[`PHX_CALL_TGT_LO +: 32];
	assign pfxImm = pfx[`PHX_PFX_IMM_LO +: 32];

	always_comb begin
		case (opc)
			// Immediate, displacement and branch forms
			OP_ADDI, OP_SUBFI, OP_ANDI, OP_ORI, OP_XORI, OP_CMPI, OP_RET,
			OP_LDB, OP_LDBU, OP_LDW, OP_LDWU, OP_LDT,
			OP_STB, OP_STW, OP_STT, OP_Bcc:
				imm = {{(`PHX_IMM_W-16){imm16[15]}}, imm16};
			OP_CALL, OP_BSR:
				imm = {{(`PHX_IMM_W-32){1'b0}}, target};
			default:
				imm = '0;
		endcase
		// Prefix supplies the upper bits
		if (pfxValid)
			imm[`PHX_IMM_W-1:16] = {{(`PHX_IMM_W-48){pfxImm[31]}}, pfxImm};
	end

endmodule

//--- logic/phxOpClassDecode.sv
`include "phx_params.svh"

module phxOpClassDecode (
	input  logic [`PHX_INSN_W-1:0] insn,
	input  logic [`PHX_INSN_W-1:0] pfx,
	output logic isLoad,
	output logic isStore,
	output logic loadReg,
	output logic loadIdx,
	output logic storeReg,
	output logic storeIdx,
	output logic loadUnsigned,
	output logic isBranch,
	output logic isCall,
	output logic multiCycle,
	output phxPkg::memSize_e baseSize,
	output phxPkg::prec_e prec
);
	import phxPkg::*;

	opcode_e opc;
	func_e fn;
	logic pfxValid;
	logic precFromField;

	assign opc = opcode_e'(insn[`PHX_OPC_HI:`PHX_OPC_LO]);
	assign fn = func_e'(insn[`PHX_FUNC_LO +: $bits(func_e)]);
	assign pfxValid = opcode_e'(pfx[`PHX_OPC_HI:`PHX_OPC_LO]) == OP_PFX;

	// ====================
	// Class and size
	// ====================
	always_comb begin
		loadReg = 1'b0;
		loadIdx = 1'b0;
		storeReg = 1'b0;
		storeIdx = 1'b0;
		multiCycle = 1'b0;
		precFromField = 1'b0;
		baseSize = TETRA;
		case (opc)
			OP_R2:
				case (fn)
					ADD, SUB, AND, OR, XOR, CMP, SLL, SRL, SRA:
						precFromField = 1'b1;
					LDBX, LDBUX: begin
						loadIdx = 1'b1;
						baseSize = BYT;
					end
					LDWX, LDWUX: begin
						loadIdx = 1'b1;
						baseSize = WYDE;
					end
					LDTX:
						loadIdx = 1'b1;
					STBX: begin
						storeIdx = 1'b1;
						baseSize = BYT;
					end
					STWX: begin
						storeIdx = 1'b1;
						baseSize = WYDE;
					end
					STTX:
						storeIdx = 1'b1;
					default: ;
				endcase
			OP_ADDI, OP_SUBFI, OP_ANDI, OP_ORI, OP_XORI, OP_CMPI:
				precFromField = 1'b1;
			OP_FMA, OP_FMS, OP_FNMA, OP_FNMS:
				multiCycle = 1'b1;
			OP_LDB, OP_LDBU: begin
				loadReg = 1'b1;
				baseSize = BYT;
			end
			OP_LDW, OP_LDWU: begin
				loadReg = 1'b1;
				baseSize = WYDE;
			end
			OP_LDT:
				loadReg = 1'b1;
			OP_STB: begin
				storeReg = 1'b1;
				baseSize = BYT;
			end
			OP_STW: begin
				storeReg = 1'b1;
				baseSize = WYDE;
			end
			OP_STT:
				storeReg = 1'b1;
			default: ;
		endcase
	end

	assign isLoad = loadReg | loadIdx;
	assign isStore = storeReg | storeIdx;
	assign loadUnsigned = (opc == OP_LDBU) || (opc == OP_LDWU) ||
		(opc == OP_R2 && (fn == LDBUX || fn == LDWUX));
	assign isBranch = opc == OP_Bcc;
	assign isCall = (opc == OP_CALL) || (opc == OP_BSR);

	// Prefix precision wins over the instruction's own field
	always_comb begin
		if (pfxValid)
			prec = prec_e'(pfx[`PHX_PFX_PREC_LO +: $bits(prec_e)]);
		else if (precFromField)
			prec = prec_e'(insn[`PHX_PREC_LO +: $bits(prec_e)]);
		else
			prec = PRC32;
	end

endmodule

//--- logic/phxPkg.sv
`include "phx_params.svh"

package phxPkg;

	// Register specifier, vector bit is the MSB
	typedef struct packed {
		logic vec;
		logic [`PHX_REG_W-2:0] num;
	} regSpec_t;

	// ====================
	// Major opcodes
	// ====================
	typedef enum logic [5:0] {
		OP_NOP   = 6'h00,
		OP_R2    = 6'h02,
		OP_ADDI  = 6'h04,
		OP_SUBFI = 6'h05,
		OP_ANDI  = 6'h08,
		OP_ORI   = 6'h09,
		OP_XORI  = 6'h0A,
		OP_CMPI  = 6'h0B,
		OP_CALL  = 6'h10,
		OP_BSR   = 6'h11,
		OP_RET   = 6'h12,
		OP_Bcc   = 6'h14,
		OP_FMA   = 6'h20,
		OP_FMS   = 6'h21,
		OP_FNMA  = 6'h22,
		OP_FNMS  = 6'h23,
		OP_LDB   = 6'h28,
		OP_LDBU  = 6'h29,
		OP_LDW   = 6'h2A,
		OP_LDWU  = 6'h2B,
		OP_LDT   = 6'h2C,
		OP_STB   = 6'h30,
		OP_STW   = 6'h31,
		OP_STT   = 6'h32,
		OP_PFX   = 6'h3F
	} opcode_e;

	// ====================
	// R2 function codes
	// ====================
	typedef enum logic [5:0] {
		ADD   = 6'h04,
		SUB   = 6'h05,
		AND   = 6'h08,
		OR    = 6'h09,
		XOR   = 6'h0A,
		CMP   = 6'h0B,
		SLL   = 6'h10,
		SRL   = 6'h11,
		SRA   = 6'h12,
		LDBX  = 6'h28,
		LDBUX = 6'h29,
		LDWX  = 6'h2A,
		LDWUX = 6'h2B,
		LDTX  = 6'h2C,
		STBX  = 6'h30,
		STWX  = 6'h31,
		STTX  = 6'h32
	} func_e;

	typedef enum logic [1:0] {
		PRC16  = 2'd0,
		PRC32  = 2'd1,
		PRC64  = 2'd2,
		PRC128 = 2'd3
	} prec_e;

	// Memory access size, VECT for vector element stepping
	typedef enum logic [1:0] {
		BYT   = 2'd0,
		WYDE  = 2'd1,
		TETRA = 2'd2,
		VECT  = 2'd3
	} memSize_e;

endpackage

//--- logic/phxRegSpecDecode.sv
`include "phx_params.svh"

module phxRegSpecDecode (
	input  logic [`PHX_INSN_W-1:0] insn,
	input  logic [2:0] spSel,
	input  logic isBranch,
	input  logic isStore,
	input  logic isCall,
	input  logic isLoad,
	input  logic loadIdx,
	input  logic storeIdx,
	input  logic storeReg,
	input  logic loadReg,
	input  phxPkg::memSize_e baseSize,
	output phxPkg::regSpec_t ra,
	output phxPkg::regSpec_t rb,
	output phxPkg::regSpec_t rc,
	output phxPkg::regSpec_t rt,
	output logic hasRa,
	output logic hasRb,
	output logic hasRc,
	output logic hasRt,
	output logic rfWr,
	output logic vrfWr,
	output logic isVector,
	output logic needSteps,
	output phxPkg::memSize_e memSize
);
	import phxPkg::*;

	opcode_e opc;
	func_e fn;
	logic [1:0] link;
	logic isFma;
	logic wrClass;
	regSpec_t raFld, rbFld, rcFld, rtFld;
	regSpec_t rcSel, rtSel;

	// Scalar r31 maps onto one of r60..r63 for the selected mode
	function automatic regSpec_t spRemap(input regSpec_t r, input logic [2:0] sel);
		regSpec_t res;
		res = r;
		if (!r.vec && r.num == 6'(`PHX_SP_REG) && sel >= 3'd1 && sel <= 3'd4)
			res.num = 6'(`PHX_SP_BASE - 1) + 6'(sel);
		return res;
	endfunction

	assign opc = opcode_e'(insn[`PHX_OPC_HI:`PHX_OPC_LO]);
	assign fn = func_e'(insn[`PHX_FUNC_LO +: $bits(func_e)]);
	assign link = insn[`PHX_CALL_RT_LO +: 2];
	assign isFma = opc inside {OP_FMA, OP_FMS, OP_FNMA, OP_FNMS};

	assign raFld = regSpec_t'(insn[`PHX_RA_LO +: `PHX_REG_W]);
	assign rbFld = regSpec_t'(insn[`PHX_RB_LO +: `PHX_REG_W]);
	assign rcFld = regSpec_t'(insn[`PHX_RC_LO +: `PHX_REG_W]);
	assign rtFld = regSpec_t'(insn[`PHX_RT_LO +: `PHX_REG_W]);

	// ====================
	// Target selection
	// ====================
	always_comb begin
		case (opc)
			OP_R2:
				case (fn)
					ADD, SUB, AND, OR, XOR, CMP, SLL, SRL, SRA: wrClass = 1'b1;
					default: wrClass = isLoad;
				endcase
			OP_ADDI, OP_SUBFI, OP_ANDI, OP_ORI, OP_XORI, OP_CMPI,
			OP_FMA, OP_FMS, OP_FNMA, OP_FNMS, OP_RET:
				wrClass = 1'b1;
			default: wrClass = isLoad;
		endcase
	end

	always_comb begin
		if (wrClass)
			rtSel = rtFld;
		else if (isCall && link != 2'd0)
			rtSel = '{vec: 1'b0, num: 6'(`PHX_LINK_BASE) + 6'(link)};
		else
			rtSel = '0;
	end

	// Branches and stores carry their data register in the Rt slot
	assign rcSel = (isBranch | isStore) ? rtFld : rcFld;

	assign ra = spRemap(raFld, spSel);
	assign rb = spRemap(rbFld, spSel);
	assign rc = spRemap(rcSel, spSel);
	assign rt = spRemap(rtSel, spSel);

	always_comb begin
		vrfWr = wrClass & rtFld.vec;
		rfWr = (wrClass & ~rtFld.vec) | (isCall & (link != 2'd0));
		// r0 is hardwired
		if (rt.num == '0)
			rfWr = 1'b0;
	end

	assign hasRa = (opc != OP_PFX) && !isCall;
	assign hasRb = (opc == OP_R2) || isFma;
	assign hasRc = isBranch | isStore | isFma;
	assign hasRt = opc != OP_PFX;

	assign isVector = (hasRt & rt.vec) | (hasRa & ra.vec) | (hasRb & rb.vec) | (hasRc & rc.vec);

	always_comb begin
		if ((hasRa & ra.vec) | (hasRt & rt.vec) | ((loadIdx | storeIdx) & hasRb & rb.vec))
			memSize = VECT;
		else
			memSize = baseSize;
	end

	// Register-form access with a scalar base walks no elements
	assign needSteps = (memSize == VECT) && !((loadReg | storeReg) && !ra.vec);

endmodule

//--- logic/phx_params.svh
`ifndef PHX_PARAMS_SVH
`define PHX_PARAMS_SVH

// ====================
// Word and field widths
// ====================
`define PHX_INSN_W 40
`define PHX_IMM_W 64
// 6-bit register number with the vector bit on top
`define PHX_REG_W 7

// ====================
// Field positions in the 40-bit word
// ====================
`define PHX_OPC_LO 0
`define PHX_OPC_HI 5
`define PHX_RT_LO 6
`define PHX_RA_LO 13
`define PHX_RB_LO 20
`define PHX_RC_LO 27
`define PHX_FUNC_LO 27
`define PHX_IMM16_LO 20
`define PHX_PREC_LO 37
`define PHX_CALL_RT_LO 6
`define PHX_CALL_TGT_LO 8
`define PHX_PFX_IMM_LO 6
`define PHX_PFX_PREC_LO 38

// Stack pointer and link register numbers
`define PHX_SP_REG 31
`define PHX_SP_BASE 60
`define PHX_LINK_BASE 48

`endif

//--- project.f
+incdir+logic
logic/phxPkg.sv
logic/phxOpClassDecode.sv
logic/phxRegSpecDecode.sv
logic/phxImmDecode.sv
logic/phxDecoder.sv
tb/phxDecoder_assert.sv
tb/phxDecoderTb.sv

//--- tb/phxDecoderTb.sv
`include "phx_params.svh"

module phxDecoderTb;
	import phxPkg::*;

	// One decoded word and the fields it must produce
	typedef struct packed {
		logic [`PHX_INSN_W-1:0] insn;
		logic [`PHX_INSN_W-1:0] pfx;
		logic [2:0] spSel;
		regSpec_t ra;
		regSpec_t rb;
		regSpec_t rt;
		regSpec_t rc;
		logic [`PHX_IMM_W-1:0] imm;
		prec_e prec;
		memSize_e memSize;
		logic [13:0] flags;
	} stimEntry_t;

	// Flag bits in the same order as flagNames
	localparam logic [13:0] mHasRt = 14'h2000;
	localparam logic [13:0] mHasRb = 14'h1000;
	localparam logic [13:0] mRfWr = 14'h0800;
	localparam logic [13:0] mVrfWr = 14'h0400;
	localparam logic [13:0] mLoad = 14'h0200;
	localparam logic [13:0] mStore = 14'h0100;
	localparam logic [13:0] mUnsigned = 14'h0080;
	localparam logic [13:0] mSteps = 14'h0040;
	localparam logic [13:0] mHasRa = 14'h0020;
	localparam logic [13:0] mHasRc = 14'h0010;
	localparam logic [13:0] mMulti = 14'h0008;
	localparam logic [13:0] mBranch = 14'h0004;
	localparam logic [13:0] mCall = 14'h0002;
	localparam logic [13:0] mVector = 14'h0001;

	logic clk = 1'b0;
	logic rstN, inValid;
	logic [`PHX_INSN_W-1:0] insn, pfx;
	logic [2:0] spSel;
	logic outValid;
	regSpec_t ra, rb, rc, rt;
	logic hasRa, hasRb, hasRc, hasRt, rfWr, vrfWr, isVector, needSteps;
	memSize_e memSize;
	logic [`PHX_IMM_W-1:0] imm;
	prec_e prec;
	logic isLoad, isStore, loadUnsigned, isBranch, isCall, multiCycle;

	stimEntry_t stim[$];
	string flagNames [14] = '{"hasRt", "hasRb", "rfWr", "vrfWr", "isLoad", "isStore",
		"loadUnsigned", "needSteps", "hasRa", "hasRc", "multiCycle", "isBranch", "isCall",
		"isVector"};

	always #10 clk = ~clk;

	phxDecoder dut (.*);

	// ====================
	// Word builders
	// ====================
	function automatic regSpec_t scalarReg(input int n);
		regSpec_t r;
		r.vec = 1'b0;
		r.num = 6'(n);
		return r;
	endfunction

	function automatic regSpec_t vectorReg(input int n);
		regSpec_t r;
		r.vec = 1'b1;
		r.num = 6'(n);
		return r;
	endfunction

	function automatic logic [`PHX_INSN_W-1:0] fieldWord(input opcode_e opc,
		input regSpec_t rtF, raF, rbF, rcF, input prec_e p);
		logic [`PHX_INSN_W-1:0] w;
		w = '0;
		w[`PHX_OPC_HI:`PHX_OPC_LO] = opc;
		w[`PHX_RT_LO +: `PHX_REG_W] = rtF;
		w[`PHX_RA_LO +: `PHX_REG_W] = raF;
		w[`PHX_RB_LO +: `PHX_REG_W] = rbF;
		w[`PHX_RC_LO +: `PHX_REG_W] = rcF;
		w[`PHX_PREC_LO +: 2] = p;
		return w;
	endfunction

	// Function code sits in the low six bits of the Rc field
	function automatic logic [`PHX_INSN_W-1:0] r2Word(input func_e fn,
		input regSpec_t rtF, raF, rbF, input prec_e p);
		return fieldWord(OP_R2, rtF, raF, rbF, regSpec_t'({1'b0, fn}), p);
	endfunction

	function automatic logic [`PHX_INSN_W-1:0] immWord(input opcode_e opc,
		input regSpec_t rtF, raF, input logic [15:0] v, input prec_e p);
		logic [`PHX_INSN_W-1:0] w;
		w = fieldWord(opc, rtF, raF, scalarReg(0), scalarReg(0), p);
		w[`PHX_IMM16_LO +: 16] = v;
		return w;
	endfunction

	function automatic logic [`PHX_INSN_W-1:0] callWord(input opcode_e opc,
		input logic [1:0] link, input logic [31:0] tgt);
		logic [`PHX_INSN_W-1:0] w;
		w = '0;
		w[`PHX_OPC_HI:`PHX_OPC_LO] = opc;
		w[`PHX_CALL_RT_LO +: 2] = link;
		w[`PHX_CALL_TGT_LO +: 32] = tgt;
		return w;
	endfunction

	function automatic logic [`PHX_INSN_W-1:0] pfxWord(input logic [31:0] v, input prec_e p);
		logic [`PHX_INSN_W-1:0] w;
		w = '0;
		w[`PHX_OPC_HI:`PHX_OPC_LO] = OP_PFX;
		w[`PHX_PFX_IMM_LO +: 32] = v;
		w[`PHX_PFX_PREC_LO +: 2] = p;
		return w;
	endfunction

	// Random filler with a fixed opcode that is never a prefix
	function automatic logic [`PHX_INSN_W-1:0] randomWord(input opcode_e opc);
		logic [`PHX_INSN_W-1:0] w;
		w = {8'($urandom), $urandom};
		w[`PHX_OPC_HI:`PHX_OPC_LO] = opc;
		return w;
	endfunction

	// ====================
	// Stimulus table
	// ====================
	task automatic addEntry(input logic [`PHX_INSN_W-1:0] w, pw, input logic [2:0] sel,
		input regSpec_t eRa, eRb, eRt, eRc, input logic [`PHX_IMM_W-1:0] eImm,
		input prec_e ePrec, input memSize_e eSize, input logic [13:0] eFlags);
		stimEntry_t e;
		e.insn = w;
		e.pfx = pw;
		e.spSel = sel;
		e.ra = eRa;
		e.rb = eRb;
		e.rt = eRt;
		e.rc = eRc;
		e.imm = eImm;
		e.prec = ePrec;
		e.memSize = eSize;
		e.flags = eFlags;
		stim.push_back(e);
	endtask

	task automatic fillTable;
		int spNum [5];
		int s;
		logic [`PHX_INSN_W-1:0] w;
		spNum = '{31, 60, 61, 62, 63};
		// R2 ALU ops where Rc shows the function code
		addEntry(r2Word(ADD, scalarReg(5), scalarReg(6), scalarReg(7), PRC64),
			randomWord(OP_NOP), 3'd0, scalarReg(6), scalarReg(7), scalarReg(5), scalarReg(4),
			'0, PRC64, TETRA, mRfWr | mHasRa | mHasRb | mHasRt);
		addEntry(r2Word(SUB, vectorReg(9), scalarReg(1), scalarReg(2), PRC128),
			randomWord(OP_NOP), 3'd0, scalarReg(1), scalarReg(2), vectorReg(9), scalarReg(5),
			'0, PRC128, VECT, mVrfWr | mSteps | mHasRa | mHasRb | mHasRt | mVector);
		addEntry(r2Word(ADD, scalarReg(0), scalarReg(3), scalarReg(4), PRC16),
			randomWord(OP_NOP), 3'd0, scalarReg(3), scalarReg(4), scalarReg(0), scalarReg(4),
			'0, PRC16, TETRA, mHasRa | mHasRb | mHasRt);
		// Immediate bits 6..0 land in Rb and bits 13..7 in Rc
		addEntry(immWord(OP_ADDI, scalarReg(3), scalarReg(4), 16'hFF80, PRC32),
			randomWord(OP_NOP), 3'd0, scalarReg(4), scalarReg(0), scalarReg(3), vectorReg(63),
			64'hFFFF_FFFF_FFFF_FF80, PRC32, TETRA, mRfWr | mHasRa | mHasRt);
		for (s = 0; s < 5; s++)
			addEntry(immWord(OP_ADDI, scalarReg(31), scalarReg(31), 16'h1234, PRC64),
				randomWord(OP_NOP), 3'(s), scalarReg(spNum[s]), scalarReg(52),
				scalarReg(spNum[s]), scalarReg(36), 64'h1234, PRC64, TETRA,
				mRfWr | mHasRa | mHasRt);
		// Loads and stores
		addEntry(immWord(OP_LDBU, scalarReg(8), scalarReg(2), 16'h0010, PRC16),
			randomWord(OP_NOP), 3'd0, scalarReg(2), scalarReg(16), scalarReg(8), scalarReg(0),
			64'h10, PRC32, BYT, mRfWr | mLoad | mUnsigned | mHasRa | mHasRt);
		addEntry(immWord(OP_LDW, scalarReg(12), vectorReg(3), 16'hFFFE, PRC32),
			randomWord(OP_NOP), 3'd0, vectorReg(3), vectorReg(62), scalarReg(12), vectorReg(63),
			64'hFFFF_FFFF_FFFF_FFFE, PRC32, VECT,
			mRfWr | mLoad | mSteps | mHasRa | mHasRt | mVector);
		addEntry(immWord(OP_STT, scalarReg(20), scalarReg(4), 16'h0008, PRC32),
			randomWord(OP_NOP), 3'd0, scalarReg(4), scalarReg(8), scalarReg(0), scalarReg(20),
			64'h8, PRC32, TETRA, mStore | mHasRa | mHasRc | mHasRt);
		addEntry(r2Word(LDBUX, scalarReg(7), scalarReg(1), vectorReg(2), PRC32),
			randomWord(OP_NOP), 3'd0, scalarReg(1), vectorReg(2), scalarReg(7), scalarReg(41),
			'0, PRC32, VECT,
			mRfWr | mLoad | mUnsigned | mSteps | mHasRa | mHasRb | mHasRt | mVector);
		addEntry(r2Word(STWX, scalarReg(9), scalarReg(1), scalarReg(2), PRC32),
			randomWord(OP_NOP), 3'd0, scalarReg(1), scalarReg(2), scalarReg(0), scalarReg(9),
			'0, PRC32, WYDE, mStore | mHasRa | mHasRb | mHasRc | mHasRt);
		// Control flow and FMA
		addEntry(callWord(OP_CALL, 2'd2, 32'h8000_1234),
			randomWord(OP_NOP), 3'd0, scalarReg(17), scalarReg(1), scalarReg(50), scalarReg(0),
			64'h8000_1234, PRC32, TETRA, mRfWr | mCall | mHasRt);
		addEntry(immWord(OP_Bcc, scalarReg(3), scalarReg(5), 16'h8000, PRC32),
			randomWord(OP_NOP), 3'd0, scalarReg(5), scalarReg(0), scalarReg(0), scalarReg(3),
			64'hFFFF_FFFF_FFFF_8000, PRC32, TETRA, mHasRa | mHasRc | mHasRt | mBranch);
		addEntry(fieldWord(OP_FMA, scalarReg(1), scalarReg(2), scalarReg(3), scalarReg(4), PRC64),
			randomWord(OP_NOP), 3'd0, scalarReg(2), scalarReg(3), scalarReg(1), scalarReg(4),
			'0, PRC32, TETRA, mRfWr | mHasRa | mHasRb | mHasRc | mHasRt | mMulti);
		// Prefix widens the immediate and sets precision
		addEntry(immWord(OP_ADDI, scalarReg(6), scalarReg(7), 16'h5678, PRC16),
			pfxWord(32'hFFFF_ABCD, PRC128), 3'd0, scalarReg(7), vectorReg(56), scalarReg(6),
			scalarReg(44), 64'hFFFF_FFFF_ABCD_5678, PRC128, TETRA, mRfWr | mHasRa | mHasRt);
		// A prefix word in the instruction slot has no operands
		addEntry(pfxWord(32'h0, PRC16), randomWord(OP_NOP), 3'd0, scalarReg(0), scalarReg(0),
			scalarReg(0), scalarReg(0), '0, PRC32, TETRA, '0);
		repeat (2) begin
			w = randomWord(OP_NOP);
			w[`PHX_RA_LO +: `PHX_REG_W] = scalarReg(11);
			addEntry(w, randomWord(OP_NOP), 3'd0, scalarReg(11),
				regSpec_t'(w[`PHX_RB_LO +: `PHX_REG_W]), scalarReg(0),
				regSpec_t'(w[`PHX_RC_LO +: `PHX_REG_W]), '0, PRC32, TETRA, mHasRa | mHasRt);
		end
	endtask

	// ====================
	// Checks
	// ====================
	task automatic stopRun(input string why);
		$display("** FAIL **");
		$fatal(1, why);
	endtask

	task automatic checkRegSpec(input string what, input regSpec_t got, input regSpec_t exp);
		if (got !== exp) begin
			$display("FAILED at time %0t: %s is %s%0d, expected %s%0d", $time, what,
				got.vec ? "v" : "r", got.num, exp.vec ? "v" : "r", exp.num);
			stopRun("Register specifier mismatch");
		end
	endtask

	task automatic checkImm(input string what, input logic [`PHX_IMM_W-1:0] got,
		input logic [`PHX_IMM_W-1:0] exp);
		if (got !== exp) begin
			$display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
			stopRun("Immediate mismatch");
		end
	endtask

	task automatic checkBit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp);
			stopRun("Flag mismatch");
		end
	endtask

	task automatic checkMemSize(input string what, input memSize_e got, input memSize_e exp);
		if (got !== exp) begin
			$display("FAILED at time %0t: %s is %s, expected %s", $time, what,
				got.name(), exp.name());
			stopRun("Memory size mismatch");
		end
	endtask

	task automatic checkPrec(input string what, input prec_e got, input prec_e exp);
		if (got !== exp) begin
			$display("FAILED at time %0t: %s is %s, expected %s", $time, what,
				got.name(), exp.name());
			stopRun("Precision mismatch");
		end
	endtask

	task automatic checkEntry(input int idx, input stimEntry_t e);
		logic [13:0] got;
		int b;
		got = {hasRt, hasRb, rfWr, vrfWr, isLoad, isStore, loadUnsigned, needSteps, hasRa,
			hasRc, multiCycle, isBranch, isCall, isVector};
		checkRegSpec($sformatf("entry %0d ra", idx), ra, e.ra);
		checkRegSpec($sformatf("entry %0d rb", idx), rb, e.rb);
		checkRegSpec($sformatf("entry %0d rt", idx), rt, e.rt);
		checkRegSpec($sformatf("entry %0d rc", idx), rc, e.rc);
		checkImm($sformatf("entry %0d imm", idx), imm, e.imm);
		checkPrec($sformatf("entry %0d prec", idx), prec, e.prec);
		checkMemSize($sformatf("entry %0d memSize", idx), memSize, e.memSize);
		for (b = 0; b < 14; b++)
			checkBit($sformatf("entry %0d %s", idx, flagNames[b]), got[13-b], e.flags[13-b]);
	endtask

	task automatic applyEntry(input stimEntry_t e);
		insn <= e.insn;
		pfx <= e.pfx;
		spSel <= e.spSel;
		inValid <= 1'b1;
	endtask

	// Latency is one cycle, so this normally returns at the first falling edge
	task automatic waitOutValid(input int idx);
		int waited;
		waited = 0;
		@(negedge clk);
		while (outValid !== 1'b1) begin
			waited++;
			if (waited >= 20) begin
				$display("Timeout: outValid never rose within 20 cycles for entry %0d", idx);
				stopRun("No valid output from the decoder");
			end
			@(negedge clk);
		end
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		int c;
		int i;
		void'($urandom(32'hdac67c8f));
		rstN = 1'b0;
		inValid = 1'b1;
		insn = '0;
		pfx = '0;
		spSel = '0;
		fillTable();
		// outValid must stay low while inValid is high in reset
		for (c = 0; c < 16; c++) begin
			@(posedge clk);
			if (c == 15) begin
				rstN <= 1'b1;
				inValid <= 1'b0;
			end
			@(negedge clk);
			checkBit("outValid during reset", outValid, 1'b0);
		end
		@(posedge clk);
		applyEntry(stim[0]);
		@(negedge clk);
		checkBit("outValid after reset", outValid, 1'b0);
		for (i = 0; i < stim.size(); i++) begin
			@(posedge clk);
			if (i + 1 < stim.size())
				applyEntry(stim[i + 1]);
			else
				inValid <= 1'b0;
			waitOutValid(i);
			checkEntry(i, stim[i]);
		end
		@(posedge clk);
		@(negedge clk);
		checkBit("outValid after last entry", outValid, 1'b0);
		$display("** PASS **");
		$finish;
	end

endmodule

//--- tb/phxDecoder_assert.sv
module phxDecoderAssert (
	input logic clk,
	input logic rstN,
	input logic outValid,
	input logic rfWr,
	input logic vrfWr,
	input logic isVector,
	input phxPkg::regSpec_t rt,
	input phxPkg::memSize_e memSize
);
	import phxPkg::*;

	// ====================
	// Output stage rules
	// ====================
	resetClearsValid: assert property (@(posedge clk) !rstN |=> !outValid)
		else $error("outValid set in the cycle after reset");

	oneWriteEnable: assert property (@(posedge clk) disable iff (!rstN) !(rfWr && vrfWr))
		else $error("rfWr and vrfWr both set");

	// r0 is hardwired and never written
	noWriteToZero: assert property (@(posedge clk) disable iff (!rstN)
		rfWr |-> rt.num != '0)
		else $error("rfWr set with Rt number zero");

	vectSizeIsVector: assert property (@(posedge clk) disable iff (!rstN)
		outValid && memSize == VECT |-> isVector)
		else $error("memSize is VECT without isVector");

endmodule

bind phxDecoder phxDecoderAssert uAssert (
	.clk(clk),
	.rstN(rstN),
	.outValid(outValid),
	.rfWr(rfWr),
	.vrfWr(vrfWr),
	.isVector(isVector),
	.rt(rt),
	.memSize(memSize)
);
